//--- common/fpga_subsys_pkg.sv
////////////////////////////////////////
// Shared widths, counts and register map for the motor subsystem
// Imported by every RTL module of the SPI register path and outputs
////////////////////////////////////////
`default_nettype none

package fpga_subsys_pkg;

    ////////////////////////////////////////
    // Bus and frame widths
    ////////////////////////////////////////
    localparam int ADDR_W         = 6;          // Register address width
    localparam int DATA_W         = 8;          // Register data width
    localparam int SPI_FRAME_BITS = 16;         // Bits per SPI transaction

    ////////////////////////////////////////
    // Channel counts
    ////////////////////////////////////////
    localparam int NUM_DRIVE      = 4;          // Drive motors, one UART each
    localparam int NUM_SERVO      = 4;          // Arm servos, one PWM each

    ////////////////////////////////////////
    // Register map
    ////////////////////////////////////////
    // Drive commands sit at 0x00..0x03, servo positions at 0x04..0x07
    localparam logic [ADDR_W-1:0] REG_DRIVE_BASE = 6'h00;  // First drive command
    localparam logic [ADDR_W-1:0] REG_SERVO_BASE = 6'h04;  // First servo position
    localparam logic [ADDR_W-1:0] REG_FAULT      = 6'h08;  // Motor faults, read only

endpackage

`default_nettype wire

//--- hdl/fpga_subsys_top.sv
////////////////////////////////////////
// Top of the motor subsystem, SPI in, UART and servo PWM out
// Set BAUD_DIV to clock cycles per UART bit
////////////////////////////////////////
`default_nettype none

module fpga_subsys_top import fpga_subsys_pkg::*; #(
    parameter int BAUD_DIV = 116                    // 115200 baud at the board clock
) (
    // Clock and reset
    input  wire                 clock,              // Main clock
    input  wire                 arst_n,             // Async reset, active low

    // SPI from the host
    input  wire                 spi_clock,          // SPI clock, mode 0
    input  wire                 cs_n,               // Chip select, active low
    input  wire                 mosi,               // Master out slave in
    output wire                 miso,               // Master in slave out

    // Motors and servos
    input  wire [NUM_DRIVE-1:0] motor_fault,        // Fault pins from drive controllers
    output wire [NUM_DRIVE-1:0] sd_uart,            // Swerve drive UART lines
    output wire [NUM_SERVO-1:0] servo_pwm,          // Arm servo PWM waves
    output wire                 status_fault        // Fault LED
);

    wire [ADDR_W-1:0]           address;            // Read / write address
    wire                        write_en;           // Write strobe
    wire [DATA_W-1:0]           wr_data;            // Write data
    wire                        read_en;            // Read strobe
    wire [DATA_W-1:0]           rd_data;            // Read data
    wire [NUM_DRIVE*DATA_W-1:0] drive_cmd;          // Drive bytes, flat
    wire [NUM_SERVO*DATA_W-1:0] servo_pos;          // Servo positions, flat

    ////////////////////////////////////////
    // SPI slave and register file
    ////////////////////////////////////////
    spi_slave spi0 (
        .clock        (clock),
        .arst_n       (arst_n),
        .spi_clock    (spi_clock),
        .cs_n         (cs_n),
        .mosi         (mosi),
        .rd_data      (rd_data),
        .miso         (miso),
        .address      (address),
        .write_en     (write_en),
        .wr_data      (wr_data),
        .read_en      (read_en)
    );

    reg_file rf0 (
        .clock        (clock),
        .arst_n       (arst_n),
        .address      (address),
        .write_en     (write_en),
        .wr_data      (wr_data),
        .read_en      (read_en),
        .motor_fault  (motor_fault),
        .rd_data      (rd_data),
        .drive_cmd    (drive_cmd),
        .servo_pos    (servo_pos),
        .status_fault (status_fault)
    );

    ////////////////////////////////////////
    // Output side
    ////////////////////////////////////////
    for (genvar i = 0; i < NUM_DRIVE; i++) begin : g_drive
        drive_uart_tx #(.BAUD_DIV(BAUD_DIV)) uart_drv (
            .clock    (clock),
            .arst_n   (arst_n),
            .tx_data  (drive_cmd[i*DATA_W +: DATA_W]),  // Byte for motor i
            .uart_tx  (sd_uart[i])
        );
    end

    for (genvar i = 0; i < NUM_SERVO; i++) begin : g_servo
        servo_pwm servo_gen (
            .clock    (clock),
            .arst_n   (arst_n),
            .position (servo_pos[i*DATA_W +: DATA_W]),  // Position for servo i
            .pwm_out  (servo_pwm[i])
        );
    end

endmodule

`default_nettype wire

//--- hdl/reg_file.sv
////////////////////////////////////////
// Register file behind the SPI slave
// Drive and servo bytes out, fault bits back in
////////////////////////////////////////
`default_nettype none

module reg_file import fpga_subsys_pkg::*; (
    input  wire                         clock,          // Main clock
    input  wire                         arst_n,         // Async reset, active low
    input  wire  [ADDR_W-1:0]           address,        // Read / write address
    input  wire                         write_en,       // Write strobe
    input  wire  [DATA_W-1:0]           wr_data,        // Write data
    input  wire                         read_en,        // Read strobe
    input  wire  [NUM_DRIVE-1:0]        motor_fault,    // Async fault pins
    output logic [DATA_W-1:0]           rd_data,        // Read data, combinational
    output logic [NUM_DRIVE*DATA_W-1:0] drive_cmd,      // Drive bytes, flat
    output logic [NUM_SERVO*DATA_W-1:0] servo_pos,      // Servo positions, flat
    output logic                        status_fault    // Fault LED
);

    localparam int DRV_IDX_W = $clog2(NUM_DRIVE);
    localparam int SRV_IDX_W = $clog2(NUM_SERVO);

    logic [DATA_W-1:0]    drive_regs [NUM_DRIVE];   // Drive command bytes
    logic [DATA_W-1:0]    servo_regs [NUM_SERVO];   // Servo positions
    logic [NUM_DRIVE-1:0] fault_meta;               // First sync stage
    logic [NUM_DRIVE-1:0] fault_sync;               // Fault register contents
    logic [ADDR_W-1:0]    drive_off;                // Offset into drive block
    logic [ADDR_W-1:0]    servo_off;                // Offset into servo block
    logic                 drive_hit;
    logic                 servo_hit;

    ////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////
    assign drive_off = address - REG_DRIVE_BASE;
    assign servo_off = address - REG_SERVO_BASE;
    assign drive_hit = (address >= REG_DRIVE_BASE) && (drive_off < ADDR_W'(NUM_DRIVE));
    assign servo_hit = (address >= REG_SERVO_BASE) && (servo_off < ADDR_W'(NUM_SERVO));

    // Write side, fault register and holes ignore writes
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_DRIVE; i++) drive_regs[i] <= '0;
            for (int i = 0; i < NUM_SERVO; i++) servo_regs[i] <= '0;
        end else if (write_en) begin
            if (drive_hit)
                drive_regs[drive_off[DRV_IDX_W-1:0]] <= wr_data;
            else if (servo_hit)
                servo_regs[servo_off[SRV_IDX_W-1:0]] <= wr_data;
        end
    end

    // Read mux, unmapped reads give zero
    always_comb begin
        rd_data = '0;
        if (drive_hit)
            rd_data = drive_regs[drive_off[DRV_IDX_W-1:0]];
        else if (servo_hit)
            rd_data = servo_regs[servo_off[SRV_IDX_W-1:0]];
        else if (address == REG_FAULT)
            rd_data = {{(DATA_W-NUM_DRIVE){1'b0}}, fault_sync};
    end

    ////////////////////////////////////////
    // Fault inputs
    ////////////////////////////////////////
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            fault_meta   <= '0;
            fault_sync   <= '0;
            status_fault <= 1'b0;
        end else begin
            fault_meta   <= motor_fault;
            fault_sync   <= fault_meta;             // Two flops for readback
            status_fault <= |motor_fault;           // LED one cycle behind pins
        end
    end

    // Flatten for the output side
    for (genvar i = 0; i < NUM_DRIVE; i++) begin : g_drive_out
        assign drive_cmd[i*DATA_W +: DATA_W] = drive_regs[i];
    end
    for (genvar i = 0; i < NUM_SERVO; i++) begin : g_servo_out
        assign servo_pos[i*DATA_W +: DATA_W] = servo_regs[i];
    end

    // Fault register is read only, a write there lands in no stored byte
    assert property (@(posedge clock) disable iff (!arst_n)
        (write_en && address == REG_FAULT) |=> ($stable(drive_cmd) && $stable(servo_pos)));

    // SPI slave captures rd_data with the strobe
    assert property (@(posedge clock) disable iff (!arst_n)
        read_en |-> !$isunknown(rd_data));

endmodule

`default_nettype wire

//--- motor/drive_uart_tx.sv
////////////////////////////////////////
// 8N1 transmitter that repeats one drive command byte
// Frames run back to back from reset on
////////////////////////////////////////
`default_nettype none

module drive_uart_tx import fpga_subsys_pkg::*; #(
    parameter int BAUD_DIV = 116                    // Clock cycles per bit
) (
    input  wire              clock,                 // Main clock
    input  wire              arst_n,                // Async reset, active low
    input  wire [DATA_W-1:0] tx_data,               // Byte to repeat
    output logic             uart_tx                // Serial line, idles high
);

    localparam int                BAUD_W    = $clog2(BAUD_DIV);
    localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(BAUD_DIV - 1);
    localparam logic [3:0]        STOP_BIT  = 4'(DATA_W + 1);  // Start, data, stop

    logic [BAUD_W-1:0] baud_cnt;                    // Cycles into current bit
    logic [3:0]        bit_cnt;                     // Bit slot in the frame
    logic [DATA_W-1:0] shift_reg;                   // Data bits left to send

    ////////////////////////////////////////
    // Baud and bit counters
    ////////////////////////////////////////
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (baud_cnt == BAUD_LAST) begin
            baud_cnt <= '0;
            bit_cnt  <= (bit_cnt == STOP_BIT) ? 4'd0 : bit_cnt + 4'd1;  // No gap
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    // Line driver, updates on the first cycle of each bit
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            uart_tx   <= 1'b1;                      // Idle until first start
            shift_reg <= '0;
        end else if (baud_cnt == '0) begin
            if (bit_cnt == 4'd0) begin
                uart_tx   <= 1'b0;                  // Start bit
                shift_reg <= tx_data;               // Byte fixed for this frame
            end else if (bit_cnt == STOP_BIT) begin
                uart_tx   <= 1'b1;                  // Stop bit
            end else begin
                uart_tx   <= shift_reg[0];          // LSB first
                shift_reg <= {1'b0, shift_reg[DATA_W-1:1]};
            end
        end
    end

    assert property (@(posedge clock) disable iff (!arst_n)
        bit_cnt <= STOP_BIT);

endmodule

`default_nettype wire

//--- motor/servo_pwm.sv
////////////////////////////////////////
// 8-bit frame PWM for one arm servo
// High for position cycles out of every 256
////////////////////////////////////////
`default_nettype none

module servo_pwm import fpga_subsys_pkg::*; (
    input  wire              clock,                 // Main clock
    input  wire              arst_n,                // Async reset, active low
    input  wire [DATA_W-1:0] position,              // Requested high time
    output logic             pwm_out                // PWM wave to servo
);

    logic [DATA_W-1:0] frame_cnt;                   // Free-running frame position
    logic [DATA_W-1:0] pos_held;                    // Position for this frame

    ////////////////////////////////////////
    // Frame counter and position hold
    ////////////////////////////////////////
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            frame_cnt <= '0;
            pos_held  <= '0;                        // Output low after reset
        end else begin
            frame_cnt <= frame_cnt + 1'b1;          // Wraps every 256 cycles
            if (frame_cnt == '1)
                pos_held <= position;               // Takes effect at count 0
        end
    end

    // High for counts 0 .. pos_held-1
    assign pwm_out = (frame_cnt < pos_held);

endmodule

`default_nettype wire

//--- spi/spi_slave.sv
////////////////////////////////////////
// Mode 0 SPI slave, 16-bit frames to register strobes
// Needs clock at least 8x spi_clock
////////////////////////////////////////
`default_nettype none

module spi_slave import fpga_subsys_pkg::*; (
    input  wire               clock,                // Main clock
    input  wire               arst_n,               // Async reset, active low
    input  wire               spi_clock,            // SPI clock, async
    input  wire               cs_n,                 // Chip select, async
    input  wire               mosi,                 // Serial data in, async
    input  wire  [DATA_W-1:0] rd_data,              // Read data from register file
    output logic              miso,                 // Serial data out
    output logic [ADDR_W-1:0] address,              // Latched register address
    output logic              write_en,             // One-cycle write strobe
    output logic [DATA_W-1:0] wr_data,              // Write data
    output logic              read_en               // One-cycle read strobe
);

    localparam int CNT_W      = $clog2(SPI_FRAME_BITS + 1);
    localparam int ADDR_DONE  = SPI_FRAME_BITS/2 - 1;   // Count before 8th rise
    localparam int FRAME_DONE = SPI_FRAME_BITS - 1;     // Count before last rise

    logic [2:0]                sclk_sync;           // Two sync stages plus history
    logic [1:0]                cs_sync;             // Chip select sync
    logic [1:0]                mosi_sync;           // Data sync
    logic                      sclk_rise;           // Rising SPI edge seen
    logic                      sclk_fall;           // Falling SPI edge seen
    logic                      cs_active;           // Frame in progress
    logic                      mosi_bit;            // Synced data bit
    logic [CNT_W-1:0]          bit_cnt;             // Bits received this frame
    logic [SPI_FRAME_BITS-2:0] shift_in;            // All but the last bit
    logic [DATA_W-1:0]         tx_shift;            // Read data going out

    ////////////////////////////////////////
    // Pin synchronizers
    ////////////////////////////////////////
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            sclk_sync <= '0;
            cs_sync   <= 2'b11;                     // Deselected
            mosi_sync <= '0;
        end else begin
            sclk_sync <= {sclk_sync[1:0], spi_clock};
            cs_sync   <= {cs_sync[0], cs_n};
            mosi_sync <= {mosi_sync[0], mosi};
        end
    end

    assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
    assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];
    assign cs_active = ~cs_sync[1];
    assign mosi_bit  = mosi_sync[1];

    ////////////////////////////////////////
    // Bit counter and input shifter
    ////////////////////////////////////////
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            bit_cnt  <= '0;
            shift_in <= '0;
        end else if (!cs_active) begin
            bit_cnt  <= '0;                         // Short frames die here
        end else if (sclk_rise && bit_cnt != CNT_W'(SPI_FRAME_BITS)) begin
            bit_cnt  <= bit_cnt + 1'b1;
            shift_in <= {shift_in[SPI_FRAME_BITS-3:0], mosi_bit};  // MSB first
        end
    end

    // Strobes, one cycle after the synced edge
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            address  <= '0;
            wr_data  <= '0;
            read_en  <= 1'b0;
            write_en <= 1'b0;
        end else begin
            read_en  <= 1'b0;
            write_en <= 1'b0;
            if (cs_active && sclk_rise) begin
                if (bit_cnt == CNT_W'(ADDR_DONE)) begin
                    address <= {shift_in[ADDR_W-2:0], mosi_bit};  // Bits 13..8
                    read_en <= ~shift_in[ADDR_DONE-1];            // Bit 15 low
                end
                if (bit_cnt == CNT_W'(FRAME_DONE)) begin
                    wr_data  <= {shift_in[DATA_W-2:0], mosi_bit};
                    write_en <= shift_in[FRAME_DONE-1];           // Bit 15 high
                end
            end
        end
    end

    ////////////////////////////////////////
    // Read data out on miso
    ////////////////////////////////////////
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            tx_shift <= '0;
            miso     <= 1'b0;
        end else if (!cs_active) begin
            tx_shift <= '0;                         // Write frames send zeros
            miso     <= 1'b0;
        end else if (read_en) begin
            tx_shift <= rd_data;                    // Capture with the strobe
        end else if (sclk_fall && bit_cnt > CNT_W'(ADDR_DONE)
                     && bit_cnt < CNT_W'(SPI_FRAME_BITS)) begin
            miso     <= tx_shift[DATA_W-1];         // Next bit for master
            tx_shift <= {tx_shift[DATA_W-2:0], 1'b0};
        end
    end

    // Read fires mid-frame, write at frame end
    assert property (@(posedge clock) disable iff (!arst_n)
        !(write_en && read_en));

endmodule

`default_nettype wire

//--- verification/tb_tasks.svh
////////////////////////////////////////
// SPI, UART and PWM driver and checker tasks
// Included inside the testbench top module
////////////////////////////////////////
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

////////////////////////////////////////
// Failure reporting
////////////////////////////////////////
task automatic stop_on_failure;
    $display("Checks failed");
    $fatal(1);
endtask

// Compare observed against expected, stop at the first mismatch
task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
        stop_on_failure();
    end
endtask

////////////////////////////////////////
// SPI master, mode 0, MSB first
////////////////////////////////////////
task automatic spi_xfer(input logic [15:0] frame, output logic [7:0] rx);
    rx = '0;
    @(negedge clock);
    cs_n = 1'b0;                                    // Select before first edge
    for (int i = 15; i >= 0; i--) begin
        spi_clock = 1'b0;
        mosi      = frame[i];                       // Data changes with clock low
        repeat (SPI_HALF) @(negedge clock);
        if (i < 8)
            rx = {rx[6:0], miso};                   // Sampled just before the rise
        spi_clock = 1'b1;
        repeat (SPI_HALF) @(negedge clock);
    end
    spi_clock = 1'b0;
    repeat (SPI_HALF) @(negedge clock);
    cs_n = 1'b1;
    mosi = 1'b0;
    repeat (2 * SPI_HALF) @(negedge clock);         // Gap between frames
endtask

task automatic spi_write(input logic [5:0] addr, input logic [7:0] data);
    logic [7:0] unused_rx;
    spi_xfer({1'b1, 1'b0, addr, data}, unused_rx);  // Bit 15 set for write
endtask

task automatic spi_read(input logic [5:0] addr, output logic [7:0] data);
    spi_xfer({1'b0, 1'b0, addr, 8'h00}, data);
endtask

////////////////////////////////////////
// UART receiver and PWM meter
////////////////////////////////////////
task automatic get_uart_frame(input int lane, output logic [7:0] data, output logic stop);
    logic prev;
    logic found;
    int   waited;
    prev   = 1'b0;
    found  = 1'b0;
    waited = 0;
    data   = '0;
    while (!found) begin
        @(negedge clock);
        if (prev && !sd_uart[lane] && frame_phase == 0)
            found = 1'b1;                           // Falling edge at a frame boundary
        prev = sd_uart[lane];
        waited++;
        if (!found && waited > UART_TIMEOUT) begin
            $display("Timeout waiting for a start bit on sd_uart[%0d]", lane);
            stop_on_failure();
        end
    end
    repeat (BAUD_DIV / 2) @(negedge clock);         // Middle of the start bit
    check($sformatf("sd_uart[%0d] start", lane), 32'(sd_uart[lane]), 32'd0);
    for (int b = 0; b < 8; b++) begin
        repeat (BAUD_DIV) @(negedge clock);
        data[b] = sd_uart[lane];                    // LSB first
    end
    repeat (BAUD_DIV) @(negedge clock);
    stop = sd_uart[lane];
endtask

// Any 256 consecutive cycles hold exactly one PWM period
task automatic measure_pwm(input int idx, output int high);
    high = 0;
    repeat (PWM_FRAME) begin
        @(negedge clock);
        if (servo_pwm[idx])
            high++;
    end
endtask

`endif

//--- verification/tb_fpga_subsys.sv
////////////////////////////////////////
// Testbench for the motor subsystem top
// Directed tests over SPI, drive UARTs, servo PWM and faults
////////////////////////////////////////
`default_nettype none

module tb_fpga_subsys;

    localparam int          BAUD_DIV     = 8;           // Short UART bits for simulation
    localparam int          FRAME_CYCLES = 10 * BAUD_DIV;   // Start, 8 data, stop
    localparam int          PWM_FRAME    = 256;         // Servo frame length
    localparam int          SPI_HALF     = 4;           // Clocks per SPI half period
    localparam int          UART_TIMEOUT = 3 * FRAME_CYCLES;
    localparam logic [5:0]  SERVO_BASE   = 6'h04;       // First servo register
    localparam logic [5:0]  FAULT_ADDR   = 6'h08;       // Fault register, read only
    localparam logic [31:0] SEED         = 32'h28bd231b;

    logic       clock;
    logic       arst_n;
    logic       spi_clock;
    logic       cs_n;
    logic       mosi;
    logic [3:0] motor_fault;
    wire        miso;
    wire  [3:0] sd_uart;
    wire  [3:0] servo_pwm;
    wire        status_fault;

    int         frame_phase;                        // Cycle within the UART frame

    fpga_subsys_top #(.BAUD_DIV(BAUD_DIV)) dut0 (
        .clock        (clock),
        .arst_n       (arst_n),
        .spi_clock    (spi_clock),
        .cs_n         (cs_n),
        .mosi         (mosi),
        .miso         (miso),
        .motor_fault  (motor_fault),
        .sd_uart      (sd_uart),
        .servo_pwm    (servo_pwm),
        .status_fault (status_fault)
    );

    `include "tb_tasks.svh"

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;                 // Period 40
    end

    // Frames start in the first cycle after reset, phase 0 is a start bit
    always @(posedge clock or negedge arst_n) begin
        if (!arst_n)
            frame_phase <= FRAME_CYCLES - 1;
        else if (frame_phase == FRAME_CYCLES - 1)
            frame_phase <= 0;
        else
            frame_phase <= frame_phase + 1;
    end

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////
    task automatic test_reset_defaults;
        logic [7:0] rd;
        int         high;
        check("miso", 32'(miso), 32'd0);            // Idle with cs_n high
        check("status_fault", 32'(status_fault), 32'd0);
        for (int a = 0; a <= 8; a++) begin
            spi_read(6'(a), rd);
            check($sformatf("reg[0x%02h]", a), 32'(rd), 32'd0);
        end
        for (int i = 0; i < 4; i++) begin
            measure_pwm(i, high);
            check($sformatf("servo_pwm[%0d] high", i), 32'(high), 32'd0);
        end
    endtask

    task automatic test_register_access;
        logic [7:0] expected [8];                   // Last byte written per address
        logic [7:0] rd;
        for (int a = 0; a < 8; a++) begin
            expected[a] = 8'($urandom);
            spi_write(6'(a), expected[a]);
        end
        for (int a = 0; a < 8; a++) begin
            spi_read(6'(a), rd);
            check($sformatf("reg[0x%02h]", a), 32'(rd), 32'(expected[a]));
        end
        spi_read(6'h20, rd);                        // Hole in the map
        check("reg[0x20]", 32'(rd), 32'd0);
        spi_write(FAULT_ADDR, 8'hff);               // Read only, no faults driven
        spi_read(FAULT_ADDR, rd);
        check("reg[0x08]", 32'(rd), 32'd0);
    endtask

    task automatic test_drive_uart;
        logic [7:0] cmd;
        logic [7:0] data;
        logic       stop;
        for (int i = 0; i < 4; i++) begin
            cmd = 8'($urandom);
            spi_write(6'(i), cmd);
            get_uart_frame(i, data, stop);          // First frame, skipped
            repeat (2) begin
                get_uart_frame(i, data, stop);
                check($sformatf("sd_uart[%0d] data", i), 32'(data), 32'(cmd));
                check($sformatf("sd_uart[%0d] stop", i), 32'(stop), 32'd1);
            end
        end
    endtask

    task automatic test_servo_pwm;
        logic [7:0] pos [4];
        int         high;
        pos = '{8'd0, 8'd1, 8'd128, 8'd255};
        for (int i = 0; i < 4; i++)
            spi_write(SERVO_BASE + 6'(i), pos[i]);
        repeat (2 * PWM_FRAME) @(negedge clock);    // New position fully in effect
        for (int i = 0; i < 4; i++) begin
            measure_pwm(i, high);
            check($sformatf("servo_pwm[%0d] high", i), 32'(high), 32'(pos[i]));
        end
    endtask

    task automatic test_faults;
        logic [3:0] patterns [6];
        logic [7:0] rd;
        patterns = '{4'b0001, 4'b1010, 4'b1111, 4'b0100, 4'b1000, 4'b0000};
        for (int i = 0; i < 6; i++) begin
            motor_fault = patterns[i];
            repeat (4) @(negedge clock);
            check("status_fault", 32'(status_fault), 32'(|patterns[i]));
            spi_read(FAULT_ADDR, rd);
            check("reg[0x08]", 32'(rd), 32'({4'b0000, patterns[i]}));
        end
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////
    initial begin
        spi_clock   = 1'b0;
        cs_n        = 1'b1;
        mosi        = 1'b0;
        motor_fault = 4'b0000;
        arst_n      = 1'b0;
        void'($urandom(SEED));                      // One seed for the whole run
        repeat (8) @(negedge clock);
        arst_n = 1'b1;
        @(negedge clock);
        test_reset_defaults();
        test_register_access();
        test_drive_uart();
        test_servo_pwm();
        test_faults();
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+verification
common/fpga_subsys_pkg.sv
spi/spi_slave.sv
hdl/reg_file.sv
motor/drive_uart_tx.sv
motor/servo_pwm.sv
hdl/fpga_subsys_top.sv
verification/tb_fpga_subsys.sv
